// File: filelist.f
usb_out_pkg.sv
usb_out_tok_if.sv
usb_out_tok_decode.sv
usb_out_xact_fsm.sv
usb_out_toggle_regs.sv
usb_out_data_put.sv
usb_out_pe.sv
tb_usb_out_pe.sv

// File: tb_usb_out_pe.sv
/*
 * Self-checking testbench for the USB OUT protocol engine
 * Replays usb_out_stim.txt one transaction per line against a toggle model
 */
`timescale 1ns/1ps

module tb_usb_out_pe import usb_out_pkg::*;;

  localparam int unsigned NumOutEps  = 4;
  localparam int unsigned PktW       = 5;
  localparam int unsigned AckTimeout = 68;
  localparam usb_addr_t   DevAddr    = 7'h05;
  localparam logic [3:0]  CtrlEps    = 4'b0001;

  // Operation codes as read from the stimulus file
  localparam int OpOut = 0, OpSetup = 1, OpSwtog = 2, OpNodata = 3, OpBadpkt = 4;

  logic clk_48mhz_i = 1'b0;
  logic rst_ni;
  logic link_reset_i, out_datatog_we_i;
  logic rx_pkt_start_i, rx_pkt_end_i, rx_pkt_valid_i, rx_data_put_i;
  logic [NumOutEps-1:0] out_ep_full_i, out_ep_stall_i, out_datatog_status_i, out_datatog_mask_i;
  usb_pid_e  rx_pid_i;
  usb_addr_t rx_addr_i;
  usb_endp_t rx_endp_i;
  usb_byte_t rx_data_i;
  usb_endp_t out_ep_current_o;
  logic out_ep_data_put_o, out_ep_newpkt_o, out_ep_acked_o, out_ep_rollback_o, tx_pkt_start_o;
  logic [PktW-1:0] out_ep_put_addr_o;
  usb_byte_t out_ep_data_o;
  logic [NumOutEps-1:0] out_ep_setup_o, out_data_toggle_o;
  usb_pid_e tx_pid_o;

  usb_out_pe dut (
    .clk_48mhz_i, .rst_ni, .link_reset_i, .dev_addr_i(DevAddr),
    .out_ep_current_o, .out_ep_data_put_o, .out_ep_put_addr_o, .out_ep_data_o,
    .out_ep_newpkt_o, .out_ep_acked_o, .out_ep_rollback_o, .out_ep_setup_o,
    .out_ep_enabled_i(4'hf), .out_ep_control_i(CtrlEps), .out_ep_full_i, .out_ep_stall_i,
    .out_data_toggle_o, .out_datatog_we_i, .out_datatog_status_i, .out_datatog_mask_i,
    .rx_pkt_start_i, .rx_pkt_end_i, .rx_pkt_valid_i, .rx_pid_i, .rx_addr_i, .rx_endp_i,
    .rx_data_put_i, .rx_data_i, .tx_pkt_start_o, .tx_pid_o
  );

  always #10 clk_48mhz_i = ~clk_48mhz_i;

  // Stimulus table
  int op_a[64], addr_a[64], endp_a[64], pid_a[64], cnt_a[64], full_a[64], stall_a[64], exp_a[64];
  int n_lines, err_cnt, fail_tests, test_errs;
  int cycles, cycle_limit;
  string test_name;
  logic [31:0] lfsr = 32'hc8de_071e;

  // Endpoint-side observations, cleared at the start of each test
  logic [PktW-1:0] put_addr_q[$];
  usb_byte_t       put_byte_q[$];
  usb_pid_e        tx_pid_q[$];
  int newpkt_n, acked_n, rollback_n;
  // Current endpoint seen together with the newpkt pulse
  usb_endp_t newpkt_ep;

  ////////////////////////////////////////
  // Monitor and run limit
  ////////////////////////////////////////

  always @(posedge clk_48mhz_i) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Run stopped, no end after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end else if (rst_ni) begin
      if (out_ep_data_put_o) begin
        put_addr_q.push_back(out_ep_put_addr_o);
        put_byte_q.push_back(out_ep_data_o);
      end
      if (tx_pkt_start_o) tx_pid_q.push_back(tx_pid_o);
      if (out_ep_newpkt_o) begin
        newpkt_n++;
        newpkt_ep = out_ep_current_o;
      end
      if (out_ep_acked_o) acked_n++;
      if (out_ep_rollback_o) rollback_n++;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Galois form, taps of x^32+x^31+x^29+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  task automatic next_byte(output usb_byte_t b);
    for (int i = 0; i < 8; i++) begin
      b[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_pid(input string what, input usb_pid_e exp, input usb_pid_e act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %s actual %s", test_name, what, exp.name(), act.name());
      test_errs++;
    end
  endtask

  task automatic check_byte(input string what, input usb_byte_t exp, input usb_byte_t act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_mask(input string what, input logic [NumOutEps-1:0] exp,
                            input logic [NumOutEps-1:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %b actual %b", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  // One packet end, address and endpoint stay on the bus afterwards
  task automatic send_pkt(input usb_pid_e pid, input logic valid, input int a, input int e);
    @(posedge clk_48mhz_i);
    rx_pkt_end_i   <= 1'b1;
    rx_pkt_valid_i <= valid;
    rx_pid_i       <= pid;
    rx_addr_i      <= usb_addr_t'(a);
    rx_endp_i      <= usb_endp_t'(e);
    @(posedge clk_48mhz_i);
    rx_pkt_end_i   <= 1'b0;
    rx_pkt_valid_i <= 1'b0;
  endtask

  task automatic put_byte(input usb_byte_t b);
    @(posedge clk_48mhz_i);
    rx_data_put_i <= 1'b1;
    rx_data_i     <= b;
    @(posedge clk_48mhz_i);
    rx_data_put_i <= 1'b0;
    repeat (2) @(posedge clk_48mhz_i);
  endtask

  function automatic int op_code(input logic [63:0] s);
    case (s)
      "OUT":    op_code = OpOut;
      "SETUP":  op_code = OpSetup;
      "SWTOG":  op_code = OpSwtog;
      "NODATA": op_code = OpNodata;
      "BADPKT": op_code = OpBadpkt;
      default:  op_code = -1;
    endcase
  endfunction

  function automatic int hs_code(input logic [63:0] s);
    case (s)
      "ACK":   hs_code = 1;
      "NAK":   hs_code = 2;
      "STALL": hs_code = 3;
      default: hs_code = 0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int fd, e, n_exp, m_hs;
    logic opened, m_tx, m_ack, m_rb, is_out, is_setup, active;
    logic [3:0] tog_m, setup_m;
    logic [63:0] op_s, exp_s;
    usb_pid_e m_pid;
    usb_byte_t b;
    usb_byte_t exp_bytes[$];
    string line;

    rst_ni = 1'b0;
    link_reset_i = 1'b0;
    out_datatog_we_i = 1'b0;
    out_datatog_status_i = '0;
    out_datatog_mask_i = '0;
    rx_pkt_start_i = 1'b0;
    rx_pkt_end_i = 1'b0;
    rx_pkt_valid_i = 1'b0;
    rx_data_put_i = 1'b0;
    rx_pid_i = UsbPidData0;
    rx_addr_i = '0;
    rx_endp_i = '0;
    rx_data_i = '0;
    out_ep_full_i = '0;
    out_ep_stall_i = '0;
    cycles = 0;
    cycle_limit = 0;
    err_cnt = 0;
    fail_tests = 0;
    n_lines = 0;
    tog_m = '0;
    setup_m = '0;

    fd = $fopen("usb_out_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file usb_out_stim.txt");
      err_cnt++;
    end else begin
      while (!$feof(fd) && n_lines < 64) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%s %h %h %h %d %d %d %s", op_s, addr_a[n_lines],
                      endp_a[n_lines], pid_a[n_lines], cnt_a[n_lines], full_a[n_lines],
                      stall_a[n_lines], exp_s) == 8 && op_code(op_s) >= 0) begin
            op_a[n_lines] = op_code(op_s);
            exp_a[n_lines] = hs_code(exp_s);
            cycle_limit += 2 * (cnt_a[n_lines] * 40 + 200);
            n_lines++;
          end else begin
            $display("Stimulus line could not be parsed: %s", line);
            err_cnt++;
          end
        end
      end
      $fclose(fd);
    end

    repeat (10) @(posedge clk_48mhz_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_48mhz_i);

    for (int n = 0; n < n_lines; n++) begin
      test_name = $sformatf("test%0d", n);
      @(negedge clk_48mhz_i);
      put_addr_q.delete();
      put_byte_q.delete();
      tx_pid_q.delete();
      newpkt_n = 0;
      newpkt_ep = '1;
      acked_n = 0;
      rollback_n = 0;
      test_errs = 0;
      e = endp_a[n];

      if (op_a[n] == OpSwtog) begin
        // Address column is the mask, endpoint column the status
        @(posedge clk_48mhz_i);
        out_datatog_we_i     <= 1'b1;
        out_datatog_mask_i   <= addr_a[n][3:0];
        out_datatog_status_i <= endp_a[n][3:0];
        @(posedge clk_48mhz_i);
        out_datatog_we_i <= 1'b0;
        tog_m = (tog_m & ~addr_a[n][3:0]) | (endp_a[n][3:0] & addr_a[n][3:0]);
        if (cnt_a[n] != 0) begin
          link_reset_i <= 1'b1;
          @(posedge clk_48mhz_i);
          link_reset_i <= 1'b0;
          tog_m = '0;
        end
        repeat (2) @(posedge clk_48mhz_i);
        @(negedge clk_48mhz_i);
        check_mask("toggles", tog_m, out_data_toggle_o);
      end else begin
        // Model of the transaction from the protocol rules
        is_setup = (op_a[n] == OpSetup);
        is_out   = !is_setup;
        active   = (addr_a[n] == DevAddr) && (e < NumOutEps);
        opened = 1'b0;
        m_tx = 1'b0;
        m_ack = 1'b0;
        m_rb = 1'b0;
        m_pid = UsbPidAck;
        if (active && is_setup) begin
          tog_m[e] = 1'b0;
          setup_m[e] = 1'b1;
          opened = CtrlEps[e];
        end
        if (active && is_out) begin
          setup_m[e] = 1'b0;
          opened = 1'b1;
        end
        if (opened && op_a[n] == OpBadpkt) begin
          m_rb = 1'b1;
        end else if (opened && is_setup) begin
          m_rb  = full_a[n] != 0;
          m_tx  = !m_rb;
          m_ack = !m_rb;
        end else if (opened && op_a[n] == OpOut) begin
          m_tx = 1'b1;
          if (pid_a[n][0] != tog_m[e] && stall_a[n] == 0) begin
            m_rb = 1'b1;
          end else if (stall_a[n] != 0) begin
            m_pid = UsbPidStall;
          end else if (full_a[n] != 0) begin
            m_pid = UsbPidNak;
            m_rb = 1'b1;
          end else begin
            m_ack = 1'b1;
          end
        end
        if (m_ack) tog_m[e] = ~tog_m[e];
        m_hs = !m_tx ? 0 : (m_pid == UsbPidAck) ? 1 : (m_pid == UsbPidNak) ? 2 : 3;
        if (m_hs != exp_a[n]) begin
          $display("Stimulus line %0d expects handshake %0d, the rules give %0d",
                   n, exp_a[n], m_hs);
          test_errs++;
        end

        @(posedge clk_48mhz_i);
        out_ep_full_i  <= (full_a[n] != 0) ? 4'(1 << e) : '0;
        out_ep_stall_i <= (stall_a[n] != 0) ? 4'(1 << e) : '0;
        send_pkt(is_setup ? UsbPidSetup : UsbPidOut, 1'b1, addr_a[n], e);
        repeat (2) @(posedge clk_48mhz_i);
        exp_bytes.delete();
        if (op_a[n] == OpNodata) begin
          repeat (AckTimeout + 10) @(posedge clk_48mhz_i);
        end else begin
          @(posedge clk_48mhz_i);
          rx_pkt_start_i <= 1'b1;
          @(posedge clk_48mhz_i);
          rx_pkt_start_i <= 1'b0;
          for (int i = 0; i < cnt_a[n]; i++) begin
            next_byte(b);
            exp_bytes.push_back(b);
            put_byte(b);
          end
          send_pkt(pid_a[n][0] ? UsbPidData1 : UsbPidData0, op_a[n] != OpBadpkt,
                   addr_a[n], e);
        end
        repeat (4) @(posedge clk_48mhz_i);
        @(negedge clk_48mhz_i);

        n_exp = opened ? exp_bytes.size() : 0;
        check_byte("newpkt count", opened, newpkt_n);
        // Token endpoint must be on the current output when newpkt pulses
        if (opened) check_byte("current endpoint", e, newpkt_ep);
        check_byte("put count", n_exp, put_byte_q.size());
        for (int i = 0; i < n_exp && i < put_byte_q.size(); i++) begin
          // Address freezes at 1 once a full endpoint sets the NAK flag
          check_byte($sformatf("put addr %0d", i),
                     (full_a[n] != 0) ? ((i == 0) ? 0 : 1) : ((i > 31) ? 31 : i),
                     put_addr_q[i]);
          check_byte($sformatf("put byte %0d", i), exp_bytes[i], put_byte_q[i]);
        end
        check_byte("handshake count", m_tx, tx_pid_q.size());
        if (m_tx && tx_pid_q.size() > 0) check_pid("handshake", m_pid, tx_pid_q[0]);
        check_byte("acked count", m_ack, acked_n);
        check_byte("rollback count", m_rb, rollback_n);
        check_mask("toggles", tog_m, out_data_toggle_o);
        check_mask("setup flags", setup_m, out_ep_setup_o);
        @(posedge clk_48mhz_i);
        out_ep_full_i  <= '0;
        out_ep_stall_i <= '0;
      end

      if (test_errs != 0) fail_tests++;
      err_cnt += test_errs;
      $display("%s op %0d: %s", test_name, op_a[n], (test_errs == 0) ? "ok" : "failed");
    end

    $display("Tests run %0d, tests failed %0d, errors %0d", n_lines, fail_tests, err_cnt);
    if (err_cnt == 0 && n_lines > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: usb_out_data_put.sv
/*
 * Forwards received data bytes to the endpoint with a byte address
 * Flags a NAK when bytes arrive for an endpoint that is full
 */
`timescale 1ns/1ps

module usb_out_data_put import usb_out_pkg::*; #(
  parameter int unsigned NumOutEps         = 4,
  parameter int unsigned MaxOutPktSizeByte = 32,
  localparam int unsigned EpIdxW           = (NumOutEps > 1) ? $clog2(NumOutEps) : 1,
  localparam int unsigned PktW             = $clog2(MaxOutPktSizeByte)
) (
  input  logic                  clk_48mhz_i,
  input  logic                  rst_ni,
  input  logic                  rx_data_put_i,
  input  usb_byte_t             rx_data_i,
  input  logic [NumOutEps-1:0]  out_ep_full_i,
  input  logic [EpIdxW-1:0]     ep_idx_i,
  input  logic                  data_phase_i,
  input  logic                  armed_i,
  output logic                  out_ep_data_put_o,
  output logic [PktW-1:0]       out_ep_put_addr_o,
  output usb_byte_t             out_ep_data_o,
  output logic                  ep_busy_o
);

  logic nak_q;
  logic ep_full;
  logic incr_addr;

  assign ep_full = out_ep_full_i[ep_idx_i];

  // Byte latch, loaded with every rx strobe
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_data_put_i) begin
      out_ep_data_o <= rx_data_i;
    end
  end

  // Put strobe lines up with the latched byte
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_data_put_o <= 1'b0;
    end else begin
      out_ep_data_put_o <= data_phase_i && rx_data_put_i;
    end
  end

  ////////////////////////////////////////
  // NAK flag and put address
  ////////////////////////////////////////

  // Any byte meeting a full endpoint spoils the whole packet
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_q <= 1'b0;
    end else if (armed_i) begin
      nak_q <= 1'b0;
    end else if (out_ep_data_put_o && ep_full) begin
      nak_q <= 1'b1;
    end
  end

  assign ep_busy_o = nak_q || ep_full;

  // Oversized packets keep overwriting the last location
  assign incr_addr = out_ep_data_put_o && !nak_q && !(&out_ep_put_addr_o);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_put_addr_o <= '0;
    end else if (armed_i) begin
      out_ep_put_addr_o <= '0;
    end else if (incr_addr) begin
      out_ep_put_addr_o <= out_ep_put_addr_o + 1'b1;
    end
  end

  // Once a NAK is pending the address stays frozen until rearmed
  addr_frozen_on_nak_a : assert property (
    @(posedge clk_48mhz_i) disable iff (!rst_ni)
    (nak_q && !armed_i) |=> $stable(out_ep_put_addr_o)
  );

endmodule

// File: usb_out_pe.sv
/*
 * Non-buffered USB full-speed protocol engine for OUT and SETUP endpoints
 * Connects the packet decoder, transaction FSM, toggle block and data path
 */
`timescale 1ns/1ps

module usb_out_pe import usb_out_pkg::*; #(
  parameter int unsigned NumOutEps         = 4,
  parameter int unsigned MaxOutPktSizeByte = 32,
  // 17 bit times at 4 clocks per bit
  parameter int unsigned AckTimeoutCnt     = 68,
  localparam int unsigned EpIdxW           = (NumOutEps > 1) ? $clog2(NumOutEps) : 1,
  localparam int unsigned PktW             = $clog2(MaxOutPktSizeByte)
) (
  input  logic                  clk_48mhz_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  usb_addr_t             dev_addr_i,

  // Endpoint side
  output usb_endp_t             out_ep_current_o,
  output logic                  out_ep_data_put_o,
  output logic [PktW-1:0]       out_ep_put_addr_o,
  output usb_byte_t             out_ep_data_o,
  output logic                  out_ep_newpkt_o,
  output logic                  out_ep_acked_o,
  output logic                  out_ep_rollback_o,
  output logic [NumOutEps-1:0]  out_ep_setup_o,
  input  logic [NumOutEps-1:0]  out_ep_enabled_i,
  input  logic [NumOutEps-1:0]  out_ep_control_i,
  input  logic [NumOutEps-1:0]  out_ep_full_i,
  input  logic [NumOutEps-1:0]  out_ep_stall_i,

  // Software access to the data toggles
  output logic [NumOutEps-1:0]  out_data_toggle_o,
  input  logic                  out_datatog_we_i,
  input  logic [NumOutEps-1:0]  out_datatog_status_i,
  input  logic [NumOutEps-1:0]  out_datatog_mask_i,

  // Receive path events
  input  logic                  rx_pkt_start_i,
  input  logic                  rx_pkt_end_i,
  input  logic                  rx_pkt_valid_i,
  input  usb_pid_e              rx_pid_i,
  input  usb_addr_t             rx_addr_i,
  input  usb_endp_t             rx_endp_i,
  input  logic                  rx_data_put_i,
  input  usb_byte_t             rx_data_i,

  // Transmit request
  output logic                  tx_pkt_start_o,
  output usb_pid_e              tx_pid_o
);

  logic [EpIdxW-1:0] ep_idx;
  logic              data_phase;
  logic              armed;
  logic              ack_done;
  logic              toggle_bad;
  logic              ep_busy;

  usb_out_tok_if #(.NumOutEps(NumOutEps)) tok ();

  usb_out_tok_decode #(
    .NumOutEps (NumOutEps)
  ) u_tok_decode (
    .dev_addr_i       (dev_addr_i),
    .rx_pkt_end_i     (rx_pkt_end_i),
    .rx_pkt_valid_i   (rx_pkt_valid_i),
    .rx_pid_i         (rx_pid_i),
    .rx_addr_i        (rx_addr_i),
    .rx_endp_i        (rx_endp_i),
    .out_ep_enabled_i (out_ep_enabled_i),
    .out_ep_control_i (out_ep_control_i),
    .tok              (tok.decode)
  );

  usb_out_xact_fsm #(
    .NumOutEps     (NumOutEps),
    .AckTimeoutCnt (AckTimeoutCnt)
  ) u_xact_fsm (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .link_reset_i      (link_reset_i),
    .rx_pkt_start_i    (rx_pkt_start_i),
    .out_ep_stall_i    (out_ep_stall_i),
    .toggle_bad_i      (toggle_bad),
    .ep_busy_i         (ep_busy),
    .tok               (tok.fsm),
    .tx_pkt_start_o    (tx_pkt_start_o),
    .tx_pid_o          (tx_pid_o),
    .out_ep_acked_o    (out_ep_acked_o),
    .out_ep_rollback_o (out_ep_rollback_o),
    .out_ep_newpkt_o   (out_ep_newpkt_o),
    .out_ep_current_o  (out_ep_current_o),
    .ep_idx_o          (ep_idx),
    .data_phase_o      (data_phase),
    .armed_o           (armed),
    .ack_done_o        (ack_done)
  );

  usb_out_toggle_regs #(
    .NumOutEps (NumOutEps)
  ) u_toggle_regs (
    .clk_48mhz_i          (clk_48mhz_i),
    .rst_ni               (rst_ni),
    .link_reset_i         (link_reset_i),
    .ep_idx_i             (ep_idx),
    .ack_done_i           (ack_done),
    .out_datatog_we_i     (out_datatog_we_i),
    .out_datatog_status_i (out_datatog_status_i),
    .out_datatog_mask_i   (out_datatog_mask_i),
    .tok                  (tok.cfg),
    .toggle_bad_o         (toggle_bad),
    .out_data_toggle_o    (out_data_toggle_o),
    .out_ep_setup_o       (out_ep_setup_o)
  );

  usb_out_data_put #(
    .NumOutEps         (NumOutEps),
    .MaxOutPktSizeByte (MaxOutPktSizeByte)
  ) u_data_put (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .rx_data_put_i     (rx_data_put_i),
    .rx_data_i         (rx_data_i),
    .out_ep_full_i     (out_ep_full_i),
    .ep_idx_i          (ep_idx),
    .data_phase_i      (data_phase),
    .armed_i           (armed),
    .out_ep_data_put_o (out_ep_data_put_o),
    .out_ep_put_addr_o (out_ep_put_addr_o),
    .out_ep_data_o     (out_ep_data_o),
    .ep_busy_o         (ep_busy)
  );

endmodule

// File: usb_out_pkg.sv
/*
 * Shared PID, state and field types for the USB OUT protocol engine
 * Every RTL module imports this package by wildcard in its header
 */
package usb_out_pkg;

  ////////////////////////////////////////
  // Fixed USB field widths
  ////////////////////////////////////////

  localparam int unsigned UsbPidW  = 4;
  localparam int unsigned UsbAddrW = 7;
  localparam int unsigned UsbEndpW = 4;
  localparam int unsigned UsbByteW = 8;

  // Two low PID bits shared by all token packets
  localparam logic [1:0] UsbPidTypeToken = 2'b01;

  typedef logic [UsbAddrW-1:0] usb_addr_t;
  typedef logic [UsbEndpW-1:0] usb_endp_t;
  typedef logic [UsbByteW-1:0] usb_byte_t;

  ////////////////////////////////////////
  // Enumerations
  ////////////////////////////////////////

  // Only the PIDs this engine receives or sends
  typedef enum logic [UsbPidW-1:0] {
    UsbPidOut   = 4'b0001,
    UsbPidAck   = 4'b0010,
    UsbPidData0 = 4'b0011,
    UsbPidNak   = 4'b1010,
    UsbPidData1 = 4'b1011,
    UsbPidSetup = 4'b1101,
    UsbPidStall = 4'b1110
  } usb_pid_e;

  // OUT transaction progress
  typedef enum logic [1:0] {
    // No transaction open
    StIdle      = 2'd0,
    // Token accepted, waiting for DATA
    StRcvdOut   = 2'd1,
    // Inside the DATA packet
    StDataStart = 2'd2,
    // One cycle to send the handshake
    StDataEnd   = 2'd3
  } out_xact_state_e;

endpackage

// File: usb_out_stim.txt
# op addr endp pid count full stall expect   (addr, endp, pid in hex; pid 1 means DATA1)
# SWTOG uses addr as toggle mask and endp as status; count 1 adds a link reset
OUT    05 1 0 8  0 0 ACK
OUT    05 1 1 5  0 0 ACK
OUT    05 2 0 28 0 0 ACK
OUT    05 2 1 40 0 0 ACK
OUT    05 1 0 6  1 0 NAK
OUT    05 1 0 3  0 1 STALL
OUT    05 1 1 4  0 0 ACK
OUT    05 1 0 4  0 0 ACK
SETUP  05 0 0 8  0 0 ACK
OUT    05 0 1 2  0 0 ACK
SETUP  05 3 0 4  0 0 NONE
SETUP  05 0 0 8  1 0 NONE
OUT    07 1 1 4  0 0 NONE
OUT    05 5 0 4  0 0 NONE
NODATA 05 1 1 0  0 0 NONE
BADPKT 05 1 1 3  0 0 NONE
OUT    05 1 1 4  0 0 ACK
OUT    05 3 0 2  0 0 ACK
SWTOG  05 a 0 0  0 0 NONE
SWTOG  0f 5 0 0  0 0 NONE
SWTOG  00 0 0 1  0 0 NONE
OUT    05 2 0 3  0 0 ACK

// File: usb_out_toggle_regs.sv
/*
 * Per-endpoint OUT data toggles and SETUP flags
 * Software may overwrite selected toggles through a masked write
 */
`timescale 1ns/1ps

module usb_out_toggle_regs import usb_out_pkg::*; #(
  parameter int unsigned NumOutEps = 4,
  localparam int unsigned EpIdxW   = (NumOutEps > 1) ? $clog2(NumOutEps) : 1
) (
  input  logic                  clk_48mhz_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  logic [EpIdxW-1:0]     ep_idx_i,
  input  logic                  ack_done_i,
  input  logic                  out_datatog_we_i,
  input  logic [NumOutEps-1:0]  out_datatog_status_i,
  input  logic [NumOutEps-1:0]  out_datatog_mask_i,
  usb_out_tok_if.cfg            tok,
  output logic                  toggle_bad_o,
  output logic [NumOutEps-1:0]  out_data_toggle_o,
  output logic [NumOutEps-1:0]  out_ep_setup_o
);

  logic [NumOutEps-1:0] toggle_q, toggle_d;
  logic                 setup_clr;
  logic                 out_seen;

  assign setup_clr = tok.setup_tok && tok.ep_active;
  assign out_seen  = tok.out_tok && tok.ep_active;

  // DATA PID that disagrees with the expected toggle
  assign toggle_bad_o = tok.data_pkt && tok.ep_active &&
                        (tok.data_pid1 != toggle_q[tok.ep_idx]);

  ////////////////////////////////////////
  // Data toggles
  ////////////////////////////////////////

  always_comb begin
    toggle_d = toggle_q;
    // SETUP always restarts the sequence at DATA0
    if (setup_clr) begin
      toggle_d[tok.ep_idx] = 1'b0;
    end
    if (ack_done_i) begin
      toggle_d[ep_idx_i] = ~toggle_q[ep_idx_i];
    end
    // Software write wins over hardware updates
    if (out_datatog_we_i) begin
      toggle_d = (toggle_d & ~out_datatog_mask_i) |
                 (out_datatog_status_i & out_datatog_mask_i);
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
    end else if (link_reset_i) begin
      toggle_q <= '0;
    end else begin
      toggle_q <= toggle_d;
    end
  end

  assign out_data_toggle_o = toggle_q;

  // Set by SETUP, cleared by the next OUT to the same endpoint
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_setup_o <= '0;
    end else if (setup_clr) begin
      out_ep_setup_o[tok.ep_idx] <= 1'b1;
    end else if (out_seen) begin
      out_ep_setup_o[tok.ep_idx] <= 1'b0;
    end
  end

  // Token decode and FSM handshake cycle never overlap
  setup_vs_ack_a : assert property (
    @(posedge clk_48mhz_i) disable iff (!rst_ni)
    !(setup_clr && ack_done_i)
  );

endmodule

// File: usb_out_tok_decode.sv
/*
 * Turns received packet ends into token, data and error events
 * Purely combinational, looks up the configuration of the addressed endpoint
 */
`timescale 1ns/1ps

module usb_out_tok_decode import usb_out_pkg::*; #(
  parameter int unsigned NumOutEps = 4
) (
  input  usb_addr_t             dev_addr_i,
  input  logic                  rx_pkt_end_i,
  input  logic                  rx_pkt_valid_i,
  input  usb_pid_e              rx_pid_i,
  input  usb_addr_t             rx_addr_i,
  input  usb_endp_t             rx_endp_i,
  input  logic [NumOutEps-1:0]  out_ep_enabled_i,
  input  logic [NumOutEps-1:0]  out_ep_control_i,
  usb_out_tok_if.decode         tok
);

  localparam int unsigned EpIdxW = (NumOutEps > 1) ? $clog2(NumOutEps) : 1;

  logic              good_end;
  logic              token_rcvd;
  logic              is_data;
  logic              ep_in_hw;
  logic [EpIdxW-1:0] ep_idx;

  // Packet end with a good CRC
  assign good_end = rx_pkt_end_i && rx_pkt_valid_i;

  // Token type and addressed to this device
  assign token_rcvd = good_end &&
                      (rx_pid_i[1:0] == UsbPidTypeToken) &&
                      (rx_addr_i == dev_addr_i);

  assign is_data = (rx_pid_i == UsbPidData0) || (rx_pid_i == UsbPidData1);

  ////////////////////////////////////////
  // Endpoint lookup
  ////////////////////////////////////////

  // Endpoint numbers beyond the implemented set fold onto index 0
  assign ep_in_hw = 32'(rx_endp_i) < NumOutEps;
  assign ep_idx   = ep_in_hw ? rx_endp_i[EpIdxW-1:0] : '0;

  assign tok.ep_idx     = ep_idx;
  // Folded index must never look active
  assign tok.ep_active  = ep_in_hw && out_ep_enabled_i[ep_idx];
  assign tok.ep_control = out_ep_control_i[ep_idx];

  ////////////////////////////////////////
  // Packet events
  ////////////////////////////////////////

  assign tok.out_tok   = token_rcvd && (rx_pid_i == UsbPidOut);
  assign tok.setup_tok = token_rcvd && (rx_pid_i == UsbPidSetup);
  assign tok.data_pkt  = good_end && is_data;
  // Bad CRC, or a good packet that is not DATA
  assign tok.other_pkt = rx_pkt_end_i && !(rx_pkt_valid_i && is_data);
  assign tok.data_pid1 = rx_pid_i[3];

endmodule

// File: usb_out_tok_if.sv
/*
 * Decoded packet events, valid only in the cycle of a packet end
 * Driven by the decoder, read by the FSM and the toggle block
 */
`timescale 1ns/1ps

interface usb_out_tok_if #(
  parameter int unsigned NumOutEps = 4
);

  localparam int unsigned EpIdxW = (NumOutEps > 1) ? $clog2(NumOutEps) : 1;

  // OUT or SETUP token to this device address
  logic              out_tok;
  logic              setup_tok;
  // Valid DATA0/DATA1, or anything else that ends a data phase
  logic              data_pkt;
  logic              other_pkt;
  // High PID bit, tells DATA1 from DATA0
  logic              data_pid1;
  // Received endpoint, 0 when not implemented
  logic [EpIdxW-1:0] ep_idx;
  logic              ep_active;
  logic              ep_control;

  modport decode (
    output out_tok, setup_tok, data_pkt, other_pkt, data_pid1,
    output ep_idx, ep_active, ep_control
  );

  modport fsm (
    input out_tok, setup_tok, data_pkt, other_pkt, data_pid1,
    input ep_idx, ep_active, ep_control
  );

  // Toggle block has no use for the error event
  modport cfg (
    input out_tok, setup_tok, data_pkt, data_pid1,
    input ep_idx, ep_active, ep_control
  );

endinterface

// File: usb_out_xact_fsm.sv
/*
 * OUT/SETUP transaction FSM with data-phase timeout and handshake choice
 * Holds the current endpoint and drives the endpoint-side strobes
 */
`timescale 1ns/1ps

module usb_out_xact_fsm import usb_out_pkg::*; #(
  parameter int unsigned NumOutEps     = 4,
  parameter int unsigned AckTimeoutCnt = 68,
  localparam int unsigned EpIdxW       = (NumOutEps > 1) ? $clog2(NumOutEps) : 1
) (
  input  logic                  clk_48mhz_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  logic                  rx_pkt_start_i,
  input  logic [NumOutEps-1:0]  out_ep_stall_i,
  input  logic                  toggle_bad_i,
  input  logic                  ep_busy_i,
  usb_out_tok_if.fsm            tok,
  output logic                  tx_pkt_start_o,
  output usb_pid_e              tx_pid_o,
  output logic                  out_ep_acked_o,
  output logic                  out_ep_rollback_o,
  output logic                  out_ep_newpkt_o,
  output usb_endp_t             out_ep_current_o,
  output logic [EpIdxW-1:0]     ep_idx_o,
  output logic                  data_phase_o,
  output logic                  armed_o,
  output logic                  ack_done_o
);

  localparam int unsigned TimeoutW = $clog2(AckTimeoutCnt + 1);

  out_xact_state_e     state_q, state_d;
  logic [TimeoutW-1:0] timeout_q, timeout_d;
  logic                xact_start;
  logic                setup_q;
  logic                new_pkt_end;
  logic                ep_stalled;

  // SETUP is only taken by control endpoints
  assign xact_start = (state_q == StIdle) && tok.ep_active &&
                      (tok.out_tok || (tok.setup_tok && tok.ep_control));

  assign ep_idx_o   = out_ep_current_o[EpIdxW-1:0];
  assign ep_stalled = out_ep_stall_i[ep_idx_o];

  ////////////////////////////////////////
  // Next state and handshake
  ////////////////////////////////////////

  always_comb begin
    state_d           = state_q;
    timeout_d         = TimeoutW'(AckTimeoutCnt);
    tx_pkt_start_o    = 1'b0;
    tx_pid_o          = UsbPidAck;
    out_ep_rollback_o = 1'b0;
    new_pkt_end       = 1'b0;

    unique case (state_q)
      StIdle: begin
        if (xact_start) begin
          state_d = StRcvdOut;
        end
      end

      StRcvdOut: begin
        // Host gets a bounded window to start the DATA packet
        timeout_d = timeout_q - 1'b1;
        if (rx_pkt_start_i) begin
          state_d = StDataStart;
        end else if (timeout_q == '0) begin
          state_d = StIdle;
        end
      end

      StDataStart: begin
        if (toggle_bad_i && !ep_stalled) begin
          // Repeated packet, our earlier ACK was probably lost
          state_d           = StIdle;
          tx_pkt_start_o    = 1'b1;
          out_ep_rollback_o = 1'b1;
        end else if (tok.other_pkt) begin
          // Corrupt or unexpected packet, no answer at all
          state_d           = StIdle;
          out_ep_rollback_o = 1'b1;
        end else if (tok.data_pkt) begin
          state_d = StDataEnd;
        end
      end

      StDataEnd: begin
        state_d        = StIdle;
        tx_pkt_start_o = 1'b1;
        if (setup_q) begin
          // A SETUP that cannot be stored is dropped silently
          if (ep_busy_i) begin
            tx_pkt_start_o    = 1'b0;
            out_ep_rollback_o = 1'b1;
          end else begin
            new_pkt_end = 1'b1;
          end
        end else if (ep_stalled) begin
          tx_pid_o = UsbPidStall;
        end else if (ep_busy_i) begin
          tx_pid_o          = UsbPidNak;
          out_ep_rollback_o = 1'b1;
        end else begin
          new_pkt_end = 1'b1;
        end
      end

      default: state_d = StIdle;
    endcase
  end

  assign out_ep_acked_o = new_pkt_end;
  assign ack_done_o     = new_pkt_end;
  assign data_phase_o   = (state_q == StDataStart);
  assign armed_o        = (state_q == StIdle) || (state_q == StRcvdOut);

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= StIdle;
      timeout_q <= TimeoutW'(AckTimeoutCnt);
    end else begin
      // Bus reset abandons any open transaction
      state_q   <= link_reset_i ? StIdle : state_d;
      timeout_q <= timeout_d;
    end
  end

  // Endpoint and transaction kind latched at the token
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_newpkt_o  <= 1'b0;
      out_ep_current_o <= '0;
      setup_q          <= 1'b0;
    end else begin
      out_ep_newpkt_o <= xact_start;
      if (xact_start) begin
        out_ep_current_o <= usb_endp_t'(tok.ep_idx);
        setup_q          <= tok.setup_tok;
      end
    end
  end

  // State register never holds X or an unknown encoding
  state_legal_a : assert property (
    @(posedge clk_48mhz_i) disable iff (!rst_ni)
    state_q inside {StIdle, StRcvdOut, StDataStart, StDataEnd}
  );

  // Handshakes only go out at the end of a data phase
  tx_in_data_phase_a : assert property (
    @(posedge clk_48mhz_i) disable iff (!rst_ni)
    tx_pkt_start_o |-> state_q inside {StDataStart, StDataEnd}
  );

endmodule
